//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the run from its log
cd "$(dirname "$0")" || exit 1

top=tb_router_input_port
log=sim.log

rm -rf obj_dir "$log"

verilator --binary -Wno-fatal --top-module "$top" -f verilog.f -o "$top" \
    && ./obj_dir/"$top" | tee "$log" \
    || { echo "Simulation build or run failed"; exit 1; }

grep -q "TEST RESULT: PASS" "$log" \
    && echo "Simulation log shows a clean run" \
    || { echo "Simulation log shows a failing run"; exit 1; }

//--- source/flit_fifo.sv
`default_nettype none

`include "noc_consts.svh"

module flit_fifo (
    input  logic           clk,
    input  logic           rst,
    input  logic           in_valid,
    input  noc_pkg::flit_t in_flit,
    output logic           in_ready,
    output logic           out_valid,
    output noc_pkg::flit_t out_flit,
    input  logic           out_ready
);

    localparam int depth = `NOC_FIFO_DEPTH;
    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);

    noc_pkg::flit_t   mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             wr_en;
    logic             rd_en;

    assign in_ready  = (count != cnt_w'(depth));    // Free space only
    assign out_valid = (count != '0);
    assign out_flit  = mem[rd_ptr];                 // Head of queue, shows after the write edge

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_flit;
        end
    end

    // ------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;            // Both or neither leave it unchanged
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/noc_consts.svh
`ifndef NOC_CONSTS_SVH
`define NOC_CONSTS_SVH

// ------------------------------------------------------------
// Torus dimensions
// ------------------------------------------------------------

`define NOC_XSIZE 4          // Nodes on each X ring
`define NOC_YSIZE 4          // Nodes on each Y ring
`define NOC_ZSIZE 4          // Nodes on each Z ring

`define NOC_COORD_W 2        // Bits per coordinate, enough for one ring

// ------------------------------------------------------------
// Flit and buffer sizing
// ------------------------------------------------------------

`define NOC_DATA_W 32        // Data word of one flit, header or payload

`define NOC_FIFO_DEPTH 4     // Input buffer entries

// Six coordinate fields sit in the header, the rest is tag
`define NOC_TAG_W (`NOC_DATA_W - 6 * `NOC_COORD_W)

`endif

//--- source/noc_pkg.sv
`default_nettype none

`include "noc_consts.svh"

package noc_pkg;

    // Output direction, same encoding the router ports use
    typedef enum logic [2:0] {
        DIR_INJECT = 3'd0,
        DIR_XPOS   = 3'd1,
        DIR_YPOS   = 3'd2,
        DIR_ZPOS   = 3'd3,
        DIR_XNEG   = 3'd4,
        DIR_YNEG   = 3'd5,
        DIR_ZNEG   = 3'd6,
        DIR_EJECT  = 3'd7
    } dir_t;

    typedef enum logic [1:0] {
        KIND_BODY      = 2'd0,
        KIND_HEAD      = 2'd1,
        KIND_TAIL      = 2'd2,
        KIND_HEAD_TAIL = 2'd3     // Single-flit packet
    } flit_kind_t;

    // ------------------------------------------------------------
    // Flit layout
    // ------------------------------------------------------------

    typedef struct packed {
        logic [`NOC_TAG_W-1:0]   tag;
        logic [`NOC_COORD_W-1:0] src_z;
        logic [`NOC_COORD_W-1:0] src_y;
        logic [`NOC_COORD_W-1:0] src_x;
        logic [`NOC_COORD_W-1:0] dst_z;
        logic [`NOC_COORD_W-1:0] dst_y;
        logic [`NOC_COORD_W-1:0] dst_x;
    } head_t;

    // Head flits read the word as coordinates, body flits as raw payload
    typedef union packed {
        head_t                  head;
        logic [`NOC_DATA_W-1:0] payload;
    } flit_data_u;

    typedef struct packed {
        flit_kind_t kind;
        flit_data_u data;
    } flit_t;

    function automatic logic is_head(input flit_kind_t kind);
        return (kind == KIND_HEAD) || (kind == KIND_HEAD_TAIL);
    endfunction

    function automatic logic is_tail(input flit_kind_t kind);
        return (kind == KIND_TAIL) || (kind == KIND_HEAD_TAIL);
    endfunction

endpackage

`default_nettype wire

//--- source/output_stage.sv
`default_nettype none

module output_stage (
    input  logic           clk,
    input  logic           rst,
    input  logic           in_valid,
    input  noc_pkg::flit_t in_flit,
    input  noc_pkg::dir_t  in_dir,
    output logic           in_ready,
    output logic [6:0]     out_valid,
    output noc_pkg::flit_t out_flit,
    input  logic [6:0]     out_ready
);

    logic [6:0] dir_onehot;
    logic       busy;
    logic       leaving;

    // Bit i stands for direction i+1, so eject lands on bit 6
    always_comb begin
        case (in_dir)
            noc_pkg::DIR_XPOS:  dir_onehot = 7'b000_0001;
            noc_pkg::DIR_YPOS:  dir_onehot = 7'b000_0010;
            noc_pkg::DIR_ZPOS:  dir_onehot = 7'b000_0100;
            noc_pkg::DIR_XNEG:  dir_onehot = 7'b000_1000;
            noc_pkg::DIR_YNEG:  dir_onehot = 7'b001_0000;
            noc_pkg::DIR_ZNEG:  dir_onehot = 7'b010_0000;
            default:            dir_onehot = 7'b100_0000;    // Eject, inject is never a way out
        endcase
    end

    assign busy     = |out_valid;
    assign leaving  = |(out_valid & out_ready);   // Only the selected output's ready counts
    assign in_ready = !busy || leaving;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= '0;
        end else if (in_ready) begin
            out_valid <= in_valid ? dir_onehot : 7'b000_0000;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_flit <= in_flit;
        end
    end

endmodule

`default_nettype wire

//--- source/port_ctrl.sv
`default_nettype none

module port_ctrl (
    input  logic           clk,
    input  logic           rst,
    input  logic           rc_valid,
    input  noc_pkg::flit_t rc_flit,
    input  noc_pkg::dir_t  rc_dir,
    output logic           rc_ready,
    output logic           fwd_valid,
    output noc_pkg::flit_t fwd_flit,
    output noc_pkg::dir_t  fwd_dir,
    input  logic           fwd_ready
);

    logic          in_pkt;            // Between a head and its tail
    logic          in_pkt_next;
    noc_pkg::dir_t held_dir;          // Direction of the current or last packet
    logic          head;
    logic          tail;
    logic          xfer;

    assign head = noc_pkg::is_head(rc_flit.kind);
    assign tail = noc_pkg::is_tail(rc_flit.kind);
    assign xfer = rc_valid && fwd_ready;

    // ------------------------------------------------------------
    // Forwarding path, no storage
    // ------------------------------------------------------------

    assign fwd_valid = rc_valid;
    assign fwd_flit  = rc_flit;
    assign rc_ready  = fwd_ready;

    // Only heads carry a fresh route, the rest follow it
    assign fwd_dir = head ? rc_dir : held_dir;

    // ------------------------------------------------------------
    // Packet state
    // ------------------------------------------------------------

    always_comb begin
        in_pkt_next = in_pkt;
        if (head) begin
            in_pkt_next = !tail;      // A head-tail packet is done at once
        end else if (tail) begin
            in_pkt_next = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            in_pkt   <= 1'b0;
            held_dir <= noc_pkg::DIR_EJECT;   // Stray flits after reset stay local
        end else if (xfer) begin
            in_pkt <= in_pkt_next;
            if (head) begin
                held_dir <= rc_dir;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/route_comp.sv
`default_nettype none

`include "noc_consts.svh"

module route_comp #(
    parameter int cur_x = 0,
    parameter int cur_y = 0,
    parameter int cur_z = 0
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           in_valid,
    input  noc_pkg::flit_t in_flit,
    output logic           in_ready,
    output logic           out_valid,
    output noc_pkg::flit_t out_flit,
    output noc_pkg::dir_t  out_dir,
    input  logic           out_ready
);

    logic [`NOC_COORD_W-1:0] dist_x;
    logic [`NOC_COORD_W-1:0] dist_y;
    logic [`NOC_COORD_W-1:0] dist_z;
    noc_pkg::dir_t           next_dir;
    logic                    load;

    // Hops from here to dst going the positive way round one ring
    function automatic logic [`NOC_COORD_W-1:0] fwd_dist(
        input logic [`NOC_COORD_W-1:0] dst,
        input int                      cur,
        input int                      size
    );
        int d;
        d = (int'(dst) + size - cur) % size;
        return d[`NOC_COORD_W-1:0];
    endfunction

    // ------------------------------------------------------------
    // Dimension order X, Y, Z with shortest way round each ring
    // ------------------------------------------------------------

    assign dist_x = fwd_dist(in_flit.data.head.dst_x, cur_x, `NOC_XSIZE);
    assign dist_y = fwd_dist(in_flit.data.head.dst_y, cur_y, `NOC_YSIZE);
    assign dist_z = fwd_dist(in_flit.data.head.dst_z, cur_z, `NOC_ZSIZE);

    always_comb begin
        if (dist_x != '0) begin
            next_dir = (dist_x <= `NOC_XSIZE / 2) ? noc_pkg::DIR_XPOS : noc_pkg::DIR_XNEG;
        end else if (dist_y != '0) begin
            next_dir = (dist_y <= `NOC_YSIZE / 2) ? noc_pkg::DIR_YPOS : noc_pkg::DIR_YNEG;
        end else if (dist_z != '0) begin
            next_dir = (dist_z <= `NOC_ZSIZE / 2) ? noc_pkg::DIR_ZPOS : noc_pkg::DIR_ZNEG;
        end else begin
            next_dir = noc_pkg::DIR_EJECT;      // Arrived at this node
        end
    end

    // Stage takes a flit when empty or when its own flit leaves this edge
    assign in_ready = !out_valid || out_ready;
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_flit <= in_flit;
            out_dir  <= next_dir;               // Garbage for body flits, ignored downstream
        end
    end

endmodule

`default_nettype wire

//--- source/router_input_port.sv
`default_nettype none

module router_input_port #(
    parameter int cur_x = 0,
    parameter int cur_y = 0,
    parameter int cur_z = 0
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           in_valid,
    input  noc_pkg::flit_t in_flit,
    output logic           in_ready,
    output logic [6:0]     out_valid,
    output noc_pkg::flit_t out_flit,
    input  logic [6:0]     out_ready
);

    // ------------------------------------------------------------
    // Stage links
    // ------------------------------------------------------------

    logic           fifo_valid;
    noc_pkg::flit_t fifo_flit;
    logic           fifo_ready;

    logic           rc_valid;
    noc_pkg::flit_t rc_flit;
    noc_pkg::dir_t  rc_dir;
    logic           rc_ready;

    logic           fwd_valid;
    noc_pkg::flit_t fwd_flit;
    noc_pkg::dir_t  fwd_dir;
    logic           fwd_ready;

    flit_fifo u_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_flit   (in_flit),
        .in_ready  (in_ready),
        .out_valid (fifo_valid),
        .out_flit  (fifo_flit),
        .out_ready (fifo_ready)
    );

    route_comp #(
        .cur_x (cur_x),
        .cur_y (cur_y),
        .cur_z (cur_z)
    ) u_route_comp (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (fifo_valid),
        .in_flit   (fifo_flit),
        .in_ready  (fifo_ready),
        .out_valid (rc_valid),
        .out_flit  (rc_flit),
        .out_dir   (rc_dir),
        .out_ready (rc_ready)
    );

    port_ctrl u_port_ctrl (
        .clk       (clk),
        .rst       (rst),
        .rc_valid  (rc_valid),
        .rc_flit   (rc_flit),
        .rc_dir    (rc_dir),
        .rc_ready  (rc_ready),
        .fwd_valid (fwd_valid),
        .fwd_flit  (fwd_flit),
        .fwd_dir   (fwd_dir),
        .fwd_ready (fwd_ready)
    );

    output_stage u_output_stage (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (fwd_valid),
        .in_flit   (fwd_flit),
        .in_dir    (fwd_dir),
        .in_ready  (fwd_ready),
        .out_valid (out_valid),
        .out_flit  (out_flit),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

//--- test/tb_router_input_port.sv
`default_nettype none

`include "noc_consts.svh"

module tb_router_input_port;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int cur_x = 1;
    localparam int cur_y = 2;
    localparam int cur_z = 3;
    localparam int max_flits = 68;                              // Upper bound over all tests
    localparam int timeout_cycles = 40 * max_flits + 200;

    logic           clk;
    logic           rst;
    logic           in_valid;
    noc_pkg::flit_t in_flit;
    logic           in_ready;
    logic [6:0]     out_valid;
    noc_pkg::flit_t out_flit;
    logic [6:0]     out_ready;

    noc_pkg::flit_t exp_flits[$];                               // Expected flits in order
    noc_pkg::dir_t  exp_dirs[$];
    int             sent_count = 0;
    int             recv_count = 0;
    int             value_errors = 0;
    int             other_errors = 0;
    int             cycle_count = 0;
    logic [31:0]    lcg_state = 32'd14850;

    router_input_port #(
        .cur_x (cur_x),
        .cur_y (cur_y),
        .cur_z (cur_z)
    ) u_dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_flit   (in_flit),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_flit  (out_flit),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Stimulus helpers and reference model
    // ------------------------------------------------------------

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int rand_coord();
        logic [31:0] r;
        r = lcg_next();
        return int'(r[17:16]);                                  // Upper bits cycle slowest
    endfunction

    // Shortest way round each ring in X, Y, Z order, ties go positive
    function automatic noc_pkg::dir_t ref_route(input int dx, input int dy, input int dz);
        int hx;
        int hy;
        int hz;
        hx = (dx - cur_x + `NOC_XSIZE) % `NOC_XSIZE;
        hy = (dy - cur_y + `NOC_YSIZE) % `NOC_YSIZE;
        hz = (dz - cur_z + `NOC_ZSIZE) % `NOC_ZSIZE;
        if (hx != 0) begin
            return (2 * hx <= `NOC_XSIZE) ? noc_pkg::DIR_XPOS : noc_pkg::DIR_XNEG;
        end
        if (hy != 0) begin
            return (2 * hy <= `NOC_YSIZE) ? noc_pkg::DIR_YPOS : noc_pkg::DIR_YNEG;
        end
        if (hz != 0) begin
            return (2 * hz <= `NOC_ZSIZE) ? noc_pkg::DIR_ZPOS : noc_pkg::DIR_ZNEG;
        end
        return noc_pkg::DIR_EJECT;
    endfunction

    function automatic noc_pkg::flit_t make_head(input noc_pkg::flit_kind_t kind,
                                                 input int dx, input int dy, input int dz);
        noc_pkg::flit_t f;
        logic [31:0]    r;
        r = lcg_next();
        f.kind = kind;
        f.data.head.tag   = r[31:12];
        f.data.head.src_x = `NOC_COORD_W'(cur_x);
        f.data.head.src_y = `NOC_COORD_W'(cur_y);
        f.data.head.src_z = `NOC_COORD_W'(cur_z);
        f.data.head.dst_x = `NOC_COORD_W'(dx);
        f.data.head.dst_y = `NOC_COORD_W'(dy);
        f.data.head.dst_z = `NOC_COORD_W'(dz);
        return f;
    endfunction

    function automatic noc_pkg::dir_t dir_of_onehot(input logic [6:0] v);
        noc_pkg::dir_t d;
        d = noc_pkg::DIR_INJECT;
        for (int i = 0; i < 7; i++) begin
            if (v[i]) begin
                d = noc_pkg::dir_t'(3'(i + 1));                 // Bit i is direction i+1
            end
        end
        return d;
    endfunction

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------

    task automatic compare_flit(input noc_pkg::flit_t got, input noc_pkg::flit_t exp,
                                input string name);
        if (got !== exp) begin
            value_errors++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_dir(input noc_pkg::dir_t got, input noc_pkg::dir_t exp,
                               input string name);
        if (got !== exp) begin
            value_errors++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_vec7(input logic [6:0] got, input logic [6:0] exp, input string name);
        if (got !== exp) begin
            value_errors++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_bit(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            value_errors++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    // ------------------------------------------------------------
    // Output monitor and run limit
    // ------------------------------------------------------------

    task automatic check_output();
        noc_pkg::flit_t exp_f;
        noc_pkg::dir_t  exp_d;
        recv_count++;
        if (!$onehot(out_valid)) begin
            other_errors++;
            $display("More than one output was valid at once at %0t", $time);
        end else if (exp_flits.size() == 0) begin
            other_errors++;
            $display("A flit left the port with none expected at %0t", $time);
        end else begin
            exp_f = exp_flits.pop_front();
            exp_d = exp_dirs.pop_front();
            compare_flit(out_flit, exp_f, "out_flit");
            compare_dir(dir_of_onehot(out_valid), exp_d, "out_valid direction");
        end
    endtask

    always @(posedge clk) begin
        if (!rst && (out_valid & out_ready) != 7'b000_0000) begin
            check_output();                                     // Values before this edge
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("Run stopped after %0d cycles without finishing the tests", cycle_count);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Drive tasks, all called on a falling edge
    // ------------------------------------------------------------

    task automatic send_flit(input noc_pkg::flit_t f, input noc_pkg::dir_t d);
        in_valid = 1'b1;
        in_flit  = f;
        exp_flits.push_back(f);
        exp_dirs.push_back(d);
        while (!in_ready) begin
            @(negedge clk);
        end
        @(negedge clk);                                         // Taken at the edge just passed
        in_valid = 1'b0;
        sent_count++;
    endtask

    task automatic send_packet(input int dx, input int dy, input int dz, input int n_flits);
        noc_pkg::dir_t  d;
        noc_pkg::flit_t f;
        d = ref_route(dx, dy, dz);
        if (n_flits == 1) begin
            send_flit(make_head(noc_pkg::KIND_HEAD_TAIL, dx, dy, dz), d);
        end else begin
            send_flit(make_head(noc_pkg::KIND_HEAD, dx, dy, dz), d);
            for (int i = 1; i < n_flits; i++) begin
                // Body words read as header would point at the mirrored node
                f = make_head(noc_pkg::KIND_BODY, `NOC_XSIZE - 1 - dx,
                              `NOC_YSIZE - 1 - dy, `NOC_ZSIZE - 1 - dz);
                if (i == n_flits - 1) begin
                    f.kind = noc_pkg::KIND_TAIL;
                end
                send_flit(f, d);
            end
        end
    endtask

    task automatic wait_drain();
        while (recv_count < sent_count) begin
            @(negedge clk);
        end
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------

    task automatic test_reset_state();
        compare_vec7(out_valid, 7'b000_0000, "out_valid");
        compare_bit(in_ready, 1'b1, "in_ready");
    endtask

    task automatic test_single_routing();
        compare_dir(ref_route(3, 0, 0), noc_pkg::DIR_XPOS, "reference tie in x");
        compare_dir(ref_route(1, 2, 1), noc_pkg::DIR_ZPOS, "reference tie in z");
        compare_dir(ref_route(1, 2, 2), noc_pkg::DIR_ZNEG, "reference negative z");
        send_packet(3, rand_coord(), rand_coord(), 1);
        send_packet(1, 2, 1, 1);
        send_packet(1, 2, 2, 1);                                // One hop back along Z
        repeat (37) begin
            send_packet(rand_coord(), rand_coord(), rand_coord(), 1);
        end
        wait_drain();
    endtask

    task automatic test_eject();
        send_packet(cur_x, cur_y, cur_z, 1);
        wait_drain();
    endtask

    task automatic test_multi_flit();
        send_packet(1, 3, 3, 5);                                // Head goes YPOS
        wait_drain();
    endtask

    task automatic test_back_pressure();
        int accepted;
        accepted = 0;
        out_ready = 7'b000_0000;
        while (in_ready && accepted < 8) begin
            send_packet(rand_coord(), rand_coord(), rand_coord(), 1);
            accepted++;
        end
        if (accepted > 6) begin
            other_errors++;
            $display("in_ready stayed high after %0d flits with all outputs stalled", accepted);
        end
        out_ready = 7'b111_1111;
        send_packet(rand_coord(), rand_coord(), rand_coord(), 1);
        send_packet(rand_coord(), rand_coord(), rand_coord(), 1);
        wait_drain();
    endtask

    task automatic test_back_to_back();
        send_packet(2, 2, 3, 3);                                // XPOS
        send_packet(0, 2, 3, 3);                                // XNEG
        send_packet(1, 1, 3, 3);                                // YNEG
        send_packet(1, 2, 0, 3);                                // ZPOS
        wait_drain();
    endtask

    initial begin
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_flit   = '0;
        out_ready = 7'b111_1111;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        test_reset_state();
        test_single_routing();
        test_eject();
        test_multi_flit();
        test_back_pressure();
        test_back_to_back();

        if (exp_flits.size() != 0) begin
            other_errors++;
            $display("%0d expected flits never left the port", exp_flits.size());
        end
        $display("Flits sent %0d, received %0d, value errors %0d, other errors %0d",
                 sent_count, recv_count, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+source
source/noc_pkg.sv
source/flit_fifo.sv
source/route_comp.sv
source/port_ctrl.sv
source/output_stage.sv
source/router_input_port.sv
test/tb_router_input_port.sv
